// ==== filelist.f ====
+incdir+verification
rtl/fifo_pkg.sv
rtl/sample_packer.sv
rtl/line_ring.sv
rtl/host_unpacker.sv
rtl/fill_monitor.sv
rtl/stream_fifo_top.sv
verification/stream_fifo_tb.sv

// ==== rtl/fifo_pkg.sv ====
`default_nettype none

package fifo_pkg;

	//////////////////////////////
	// Widths and geometry
	//////////////////////////////

	// Acquisition sample and host word
	localparam int SAMPLE_W = 16;
	localparam int HOST_W = 32;

	// One ring line carries four samples, read back as two host words
	localparam int LINE_W = 64;
	localparam int SAMPLES_PER_LINE = 4;
	localparam int HOSTS_PER_LINE = 2;

	// On-chip ring in place of the external SDRAM
	localparam int RING_LINES = 64;
	localparam int RING_ADDR_W = $clog2(RING_LINES);

	//////////////////////////////
	// Data types
	//////////////////////////////

	typedef logic [SAMPLE_W-1:0] sample_t;

	typedef logic [HOST_W-1:0] host_word_t;

	// Same 64 bits, seen as samples by the packer and as host words by the unpacker
	// Index 0 sits in the lowest bits in both views
	typedef union packed {
		sample_t [SAMPLES_PER_LINE-1:0] samples;
		host_word_t [HOSTS_PER_LINE-1:0] words;
	} line_u;

	// One-cycle line transfer between stages
	typedef struct packed {
		logic valid;
		line_u line;
	} line_beat_t;

	//////////////////////////////
	// Counts
	//////////////////////////////

	// 16-bit words held across the whole chain
	typedef logic [31:0] fill_t;

	// Ring occupancy, 0 up to RING_LINES inclusive
	typedef logic [RING_ADDR_W:0] ring_count_t;

endpackage

`default_nettype wire

// ==== rtl/fill_monitor.sv ====
`timescale 1ns/1ps
`default_nettype none

module fill_monitor (
	input wire logic okClk,
	input wire logic arst_n,
	input wire logic [1:0] held_samples,
	input fifo_pkg::ring_count_t ring_lines,
	input wire logic [1:0] pending_halves,
	output fifo_pkg::fill_t fill_words
);

	import fifo_pkg::*;

	fill_t packer_words;
	fill_t ring_words;
	fill_t host_words;
	fill_t fill_next;
	fill_t fill_q;

	// Each stage converted to 16-bit words
	assign packer_words = fill_t'(held_samples);
	assign ring_words = fill_t'(ring_lines) * fill_t'(SAMPLES_PER_LINE);
	assign host_words = fill_t'(pending_halves) * fill_t'(SAMPLES_PER_LINE / HOSTS_PER_LINE);

	assign fill_next = packer_words + ring_words + host_words;

	// Dips for one cycle while a beat moves from packer to ring
	always_ff @(posedge okClk or negedge arst_n) begin
		if (!arst_n) begin
			fill_q <= '0;
		end else begin
			fill_q <= fill_next;
		end
	end

	assign fill_words = fill_q;

endmodule

`default_nettype wire

// ==== rtl/host_unpacker.sv ====
`timescale 1ns/1ps
`default_nettype none

module host_unpacker (
	input wire logic okClk,
	input wire logic arst_n,
	input fifo_pkg::line_beat_t fetched_line,
	input wire logic host_read,
	output logic line_wanted,
	output fifo_pkg::host_word_t host_data,
	output logic [1:0] pending_halves
);

	import fifo_pkg::*;

	// Unread host words left in the held line
	logic [1:0] held_q;
	// Request went out last cycle and its line may still be on the way
	logic pending_q;
	logic next_idx;
	line_u line_q;
	host_word_t host_q;

	// Ask for a line only when empty-handed and nothing is in flight
	assign line_wanted = (held_q == 2'd0) && !pending_q;

	// With one word left the upper half is next
	assign next_idx = (held_q == 2'd1);

	always_ff @(posedge okClk or negedge arst_n) begin
		if (!arst_n) begin
			held_q <= 2'd0;
			// Keeps line_wanted low until the first cycle out of reset
			pending_q <= 1'b1;
			host_q <= '0;
		end else begin
			pending_q <= line_wanted;
			if (fetched_line.valid) begin
				held_q <= 2'(HOSTS_PER_LINE);
			end else if (host_read && held_q != 2'd0) begin
				host_q <= line_q.words[next_idx];
				held_q <= held_q - 2'd1;
			end
			// Read with nothing held leaves host_q as it was
		end
	end

	// Fetched line payload
	always_ff @(posedge okClk) begin
		if (fetched_line.valid) begin
			line_q <= fetched_line.line;
		end
	end

	assign host_data = host_q;

	// A line in flight has already left the ring count, so count it here
	assign pending_halves = held_q + (fetched_line.valid ? 2'(HOSTS_PER_LINE) : 2'd0);

	// Ring answers only the request of the previous cycle
	a_fetch_requested: assert property (@(posedge okClk) disable iff (!arst_n)
		fetched_line.valid |-> (pending_q && held_q == 2'd0))
		else $error("host_unpacker: line delivered without a pending fetch");

endmodule

`default_nettype wire

// ==== rtl/line_ring.sv ====
`timescale 1ns/1ps
`default_nettype none

module line_ring (
	input wire logic okClk,
	input wire logic arst_n,
	input fifo_pkg::line_beat_t packed_line,
	input wire logic line_wanted,
	output fifo_pkg::line_beat_t fetched_line,
	output fifo_pkg::ring_count_t ring_lines
);

	import fifo_pkg::*;

	//////////////////////////////
	// Storage and pointers
	//////////////////////////////

	logic [LINE_W-1:0] ring_mem [RING_LINES];

	logic [RING_ADDR_W-1:0] wr_ptr;
	logic [RING_ADDR_W-1:0] rd_ptr;
	ring_count_t count_q;

	logic ring_full;
	logic ring_empty;
	logic do_write;
	logic do_read;

	logic fetch_valid_q;
	line_u fetch_line_q;

	assign ring_full = (count_q == ring_count_t'(RING_LINES));
	assign ring_empty = (count_q == '0);

	// A beat arriving at a full ring is dropped
	assign do_write = packed_line.valid && !ring_full;
	assign do_read = line_wanted && !ring_empty;

	//////////////////////////////
	// Pointer and occupancy
	//////////////////////////////

	always_ff @(posedge okClk or negedge arst_n) begin
		if (!arst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count_q <= '0;
			fetch_valid_q <= 1'b0;
		end else begin
			// Pointers wrap on their own since the depth is a power of two
			if (do_write) begin
				wr_ptr <= wr_ptr + RING_ADDR_W'(1);
			end
			if (do_read) begin
				rd_ptr <= rd_ptr + RING_ADDR_W'(1);
			end
			fetch_valid_q <= do_read;

			case ({do_write, do_read})
				2'b10: count_q <= count_q + ring_count_t'(1);
				2'b01: count_q <= count_q - ring_count_t'(1);
				default: count_q <= count_q;
			endcase
		end
	end

	//////////////////////////////
	// Line storage and fetch
	//////////////////////////////

	always_ff @(posedge okClk) begin
		if (do_write) begin
			ring_mem[wr_ptr] <= packed_line.line;
		end
	end

	// Oldest line comes out one cycle after the request is seen
	always_ff @(posedge okClk) begin
		if (do_read) begin
			fetch_line_q <= ring_mem[rd_ptr];
		end
	end

	assign fetched_line = '{valid: fetch_valid_q, line: fetch_line_q};
	assign ring_lines = count_q;

	// Host has to keep the fill level below capacity
	a_no_overflow: assert property (@(posedge okClk) disable iff (!arst_n)
		packed_line.valid |-> (ring_lines != ring_count_t'(RING_LINES)))
		else $error("line_ring: line written into a full ring");

endmodule

`default_nettype wire

// ==== rtl/sample_packer.sv ====
`timescale 1ns/1ps
`default_nettype none

module sample_packer (
	input wire logic okClk,
	input wire logic arst_n,
	input wire logic sample_write,
	input fifo_pkg::sample_t sample_in,
	output fifo_pkg::line_beat_t packed_line,
	output logic [1:0] held_samples
);

	import fifo_pkg::*;

	logic [1:0] held_q;
	logic beat_valid_q;
	line_u fill_line_q;
	line_u line_next;

	// Drop the new sample into the next free slot
	always_comb begin
		line_next = fill_line_q;
		line_next.samples[held_q] = sample_in;
	end

	// Slot count and outgoing beat strobe
	always_ff @(posedge okClk or negedge arst_n) begin
		if (!arst_n) begin
			held_q <= 2'd0;
			beat_valid_q <= 1'b0;
		end else begin
			beat_valid_q <= sample_write && (held_q == 2'(SAMPLES_PER_LINE - 1));
			if (sample_write) begin
				// Wraps to zero as the fourth sample closes the group
				held_q <= held_q + 2'd1;
			end
		end
	end

	// Line under assembly
	// Stays whole through the beat cycle since the next write only touches slot 0
	always_ff @(posedge okClk) begin
		if (sample_write) begin
			fill_line_q <= line_next;
		end
	end

	assign packed_line = '{valid: beat_valid_q, line: fill_line_q};
	assign held_samples = held_q;

	// A written sample carries no unknown bits into the line
	a_sample_known: assert property (@(posedge okClk) disable iff (!arst_n)
		sample_write |-> !$isunknown(sample_in))
		else $error("sample_packer: sample written with unknown bits");

endmodule

`default_nettype wire

// ==== rtl/stream_fifo_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module stream_fifo_top (
	input wire logic okClk,
	input wire logic arst_n,
	input wire logic sample_write,
	input fifo_pkg::sample_t sample_in,
	input wire logic host_read,
	output fifo_pkg::host_word_t host_data,
	output fifo_pkg::fill_t fill_words
);

	import fifo_pkg::*;

	// Packer to ring
	line_beat_t packed_line;
	logic [1:0] held_samples;

	// Ring to unpacker
	line_beat_t fetched_line;
	logic line_wanted;
	ring_count_t ring_lines;

	// Unpacker to monitor
	logic [1:0] pending_halves;

	sample_packer u_sample_packer (
		.okClk(okClk),
		.arst_n(arst_n),
		.sample_write(sample_write),
		.sample_in(sample_in),
		.packed_line(packed_line),
		.held_samples(held_samples)
	);

	line_ring u_line_ring (
		.okClk(okClk),
		.arst_n(arst_n),
		.packed_line(packed_line),
		.line_wanted(line_wanted),
		.fetched_line(fetched_line),
		.ring_lines(ring_lines)
	);

	host_unpacker u_host_unpacker (
		.okClk(okClk),
		.arst_n(arst_n),
		.fetched_line(fetched_line),
		.host_read(host_read),
		.line_wanted(line_wanted),
		.host_data(host_data),
		.pending_halves(pending_halves)
	);

	fill_monitor u_fill_monitor (
		.okClk(okClk),
		.arst_n(arst_n),
		.held_samples(held_samples),
		.ring_lines(ring_lines),
		.pending_halves(pending_halves),
		.fill_words(fill_words)
	);

endmodule

`default_nettype wire

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the stream FIFO testbench with Verilator

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --timescale 1ns/1ps \
	-f filelist.f --top-module stream_fifo_tb \
	--Mdir obj_dir -o stream_fifo_sim; then
	echo "Verilator build failed"
	exit 1
fi

output=$(./obj_dir/stream_fifo_sim)
status=$?
printf '%s\n' "$output"

if [ "$status" -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

# Pass only if the testbench printed its pass line
if printf '%s\n' "$output" | grep -qx "test passed"; then
	exit 0
else
	echo "Pass message not found in simulation output"
	exit 1
fi

// ==== verification/stream_fifo_checks.svh ====
`ifndef STREAM_FIFO_CHECKS_SVH
`define STREAM_FIFO_CHECKS_SVH

//////////////////////////////
// Model and tallies
//////////////////////////////

// Error tallies per kind of result
int word_errors = 0;
int fill_errors = 0;

// Samples written and not yet read back, oldest first
sample_t model_q[$];

// One step of a 32-bit xorshift generator
function automatic logic [31:0] xorshift_next(input logic [31:0] state);
	logic [31:0] x;
	x = state;
	x = x ^ (x << 13);
	x = x ^ (x >> 17);
	x = x ^ (x << 5);
	return x;
endfunction

//////////////////////////////
// Compare tasks
//////////////////////////////

task automatic check_word(input host_word_t got, input host_word_t exp, input string what);
	if (got !== exp) begin
		word_errors++;
		$display("Fail at %0d ns: %s, host_data %h, expected %h", $time, what, got, exp);
	end
endtask

task automatic check_fill(input fill_t got, input fill_t exp, input string what);
	if (got !== exp) begin
		fill_errors++;
		$display("Fail at %0d ns: %s, fill_words %0d, expected %0d", $time, what, got, exp);
	end
endtask

`endif

// ==== verification/stream_fifo_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module stream_fifo_tb;

	import fifo_pkg::*;

	localparam int CLK_HALF = 50;
	localparam int RESET_CYCLES = 8;
	localparam int SETTLE_CYCLES = 4;
	localparam int CYCLES_PER_ROW = 20;
	localparam int NUM_ROWS = 22;

	typedef enum logic [1:0] {OP_WRITE, OP_READ, OP_IDLE} op_e;

	// One table row, the expected fill is taken after the settle
	typedef struct packed {
		op_e op;
		logic [15:0] count;
		fill_t exp_fill;
	} step_t;

	logic okClk;
	logic arst_n;
	logic sample_write;
	sample_t sample_in;
	logic host_read;
	host_word_t host_data;
	fill_t fill_words;

	logic [31:0] rng_state;
	host_word_t last_word;
	int written;
	int words_read;

	step_t steps [NUM_ROWS] = '{
		// Reset state and underflow on an empty chain
		'{OP_READ, 16'd1, 32'd0},
		'{OP_WRITE, 16'd8, 32'd8},
		'{OP_READ, 16'd4, 32'd0},
		// Partial group stays counted but unreadable
		'{OP_WRITE, 16'd6, 32'd6},
		'{OP_READ, 16'd2, 32'd2},
		'{OP_READ, 16'd1, 32'd2},
		'{OP_WRITE, 16'd2, 32'd4},
		'{OP_READ, 16'd2, 32'd0},
		'{OP_READ, 16'd2, 32'd0},
		'{OP_IDLE, 16'd5, 32'd0},
		// Rounds that carry both pointers past the ring end
		'{OP_WRITE, 16'd80, 32'd80},
		'{OP_READ, 16'd36, 32'd8},
		'{OP_WRITE, 16'd80, 32'd88},
		'{OP_READ, 16'd40, 32'd8},
		'{OP_WRITE, 16'd80, 32'd88},
		'{OP_READ, 16'd40, 32'd8},
		'{OP_WRITE, 16'd60, 32'd68},
		'{OP_READ, 16'd34, 32'd0},
		'{OP_WRITE, 16'd3, 32'd3},
		'{OP_READ, 16'd1, 32'd3},
		'{OP_WRITE, 16'd1, 32'd4},
		'{OP_READ, 16'd2, 32'd0}
	};

	`include "stream_fifo_checks.svh"

	stream_fifo_top u_stream_fifo_top (
		.okClk(okClk),
		.arst_n(arst_n),
		.sample_write(sample_write),
		.sample_in(sample_in),
		.host_read(host_read),
		.host_data(host_data),
		.fill_words(fill_words)
	);

	initial okClk = 1'b0;
	always #(CLK_HALF) okClk = ~okClk;

	//////////////////////////////
	// Stimulus tasks
	//////////////////////////////

	task automatic write_samples(input int n);
		sample_t s;
		for (int i = 0; i < n; i++) begin
			rng_state = xorshift_next(rng_state);
			s = rng_state[15:0];
			model_q.push_back(s);
			@(posedge okClk);
			sample_write <= 1'b1;
			sample_in <= s;
		end
		written += n;
		@(posedge okClk);
		sample_write <= 1'b0;
	endtask

	task automatic read_words(input int n);
		int remainder;
		sample_t lo;
		sample_t hi;
		for (int i = 0; i < n; i++) begin
			remainder = written % SAMPLES_PER_LINE;
			if (model_q.size() - remainder >= 2) begin
				lo = model_q.pop_front();
				hi = model_q.pop_front();
				// Readable once the fill is two words past the partial group
				while (fill_words < fill_t'(remainder + 2)) @(negedge okClk);
				@(posedge okClk);
				host_read <= 1'b1;
				@(posedge okClk);
				host_read <= 1'b0;
				@(negedge okClk);
				check_word(host_data, {hi, lo}, "read");
				last_word = {hi, lo};
				words_read++;
				// End of a line, wait until the fill shows the drop
				if (words_read % 2 == 0) begin
					while (fill_words != fill_t'(model_q.size())) @(negedge okClk);
				end
			end else begin
				@(posedge okClk);
				host_read <= 1'b1;
				@(posedge okClk);
				host_read <= 1'b0;
				@(negedge okClk);
				check_word(host_data, last_word, "underflow read");
			end
		end
	endtask

	task automatic settle_fill(input int row);
		repeat (SETTLE_CYCLES) @(posedge okClk);
		@(negedge okClk);
		check_fill(fill_words, steps[row].exp_fill, $sformatf("row %0d", row));
	endtask

	function automatic int watchdog_limit();
		int total;
		total = CYCLES_PER_ROW * NUM_ROWS;
		for (int i = 0; i < NUM_ROWS; i++) begin
			total += int'(steps[i].count);
		end
		return total;
	endfunction

	//////////////////////////////
	// Main sequence
	//////////////////////////////

	initial begin
		arst_n = 1'b0;
		sample_write = 1'b0;
		sample_in = '0;
		host_read = 1'b0;
		rng_state = 32'd54734;
		last_word = '0;
		written = 0;
		words_read = 0;
		repeat (RESET_CYCLES) @(posedge okClk);
		arst_n <= 1'b1;
		@(negedge okClk);
		check_word(host_data, '0, "after reset");
		check_fill(fill_words, '0, "after reset");
		for (int row = 0; row < NUM_ROWS; row++) begin
			case (steps[row].op)
				OP_WRITE: write_samples(int'(steps[row].count));
				OP_READ: read_words(int'(steps[row].count));
				default: repeat (int'(steps[row].count)) @(posedge okClk);
			endcase
			settle_fill(row);
		end
		$display("Errors: %0d host word, %0d fill level", word_errors, fill_errors);
		if (word_errors + fill_errors == 0) begin
			$display("test passed");
		end else begin
			$display("test failed");
		end
		$finish;
	end

	// Watchdog
	initial begin : watchdog
		int limit;
		limit = watchdog_limit();
		repeat (limit) @(posedge okClk);
		$display("Timeout: the run did not finish within %0d cycles", limit);
		$display("test failed");
		$finish;
	end

endmodule

`default_nettype wire
